//--- filelist.f
+incdir+design
design/tluh_pkg.sv
design/sram_pkg.sv
design/sram_if.sv
design/tluh_amo_alu.sv
design/sram_mem.sv
design/tluh_sram_adapter.sv
design/tluh_sram_top.sv
tests/tluh_sram_tb.sv

//--- tests/tluh_sram_tb.sv
`include "tluh_settings.svh"

module tluh_sram_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import tluh_pkg::*;

  localparam int WAIT_LIMIT = 100;

  logic       clk_i;
  logic       rst_ni;
  logic       a_valid_i;
  tl_a_op_e   a_opcode_i;
  tl_param_t  a_param_i;
  tl_size_t   a_size_i;
  tl_source_t a_source_i;
  tl_addr_t   a_address_i;
  tl_mask_t   a_mask_i;
  tl_data_t   a_data_i;
  logic       a_ready_o;
  logic       d_valid_o;
  tl_d_op_e   d_opcode_o;
  tl_size_t   d_size_o;
  tl_source_t d_source_o;
  tl_data_t   d_data_o;
  logic       d_error_o;
  logic       d_ready_i;

  // expected contents of the SRAM
  tl_data_t    model [`SRAM_DEPTH];
  int          errors = 0;
  int          checks = 0;
  int          seed = 19422;
  int          sram_writes = 0;
  logic        bp_en = 1'b0;
  logic [31:0] ready_rnd;

  tluh_sram_top u_tluh_sram_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // random D back-pressure when enabled
  initial begin
    d_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      ready_rnd = $random(seed);
      d_ready_i = bp_en ? ready_rnd[0] : 1'b1;
    end
  end

  // write cycles seen on the SRAM port
  always @(negedge clk_i) begin
    if (u_tluh_sram_top.u_sram_if.req && u_tluh_sram_top.u_sram_if.we) begin
      sram_writes++;
    end
  end

  task automatic check(input string name, input string field,
                       input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic abort(input string what);
    errors++;
    $display("timed out waiting for %s", what);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  function automatic int widx(input tl_addr_t addr);
    return int'(addr[`SRAM_AW+1:2]);
  endfunction

  function automatic tl_data_t merge_bytes(input tl_data_t old, input tl_data_t data,
                                           input tl_mask_t mask);
    tl_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // new stored value of an atomic
  function automatic tl_data_t amo_ref(input tl_param_t param, input tl_data_t old,
                                       input tl_data_t opnd);
    tl_data_t res;
    case (param)
      MIN:     res = ($signed(opnd) < $signed(old)) ? opnd : old;
      MAX:     res = ($signed(opnd) > $signed(old)) ? opnd : old;
      MINU:    res = (opnd < old) ? opnd : old;
      MAXU:    res = (opnd > old) ? opnd : old;
      ADD:     res = old + opnd;
      default: res = old;
    endcase
    return res;
  endfunction

  // holds one A beat until it is accepted
  task automatic send_a(input tl_a_op_e op, input tl_param_t param, input tl_size_t size,
                        input tl_source_t src, input tl_addr_t addr, input tl_mask_t mask,
                        input tl_data_t data);
    int n;
    n = 0;
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_param_i   = param;
    a_size_i    = size;
    a_source_i  = src;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    @(negedge clk_i);
    while (!a_ready_o) begin
      if (n == WAIT_LIMIT) begin
        abort("a_ready_o");
      end
      n++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    a_valid_i = 1'b0;
  endtask

  task automatic recv_d(input string name, input tl_d_op_e op, input tl_size_t size,
                        input tl_source_t src, input tl_data_t data, input logic chk_data,
                        input logic err);
    int         n;
    logic       held;
    logic       done;
    tl_d_op_e   h_op;
    tl_data_t   h_data;
    logic       h_err;
    tl_source_t h_src;
    tl_size_t   h_size;
    n    = 0;
    held = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      // stalled beat must not change
      if (held) begin
        check(name, "held valid", 1'b1, d_valid_o);
        check(name, "held opcode", h_op, d_opcode_o);
        check(name, "held data", h_data, d_data_o);
        check(name, "held error", h_err, d_error_o);
        check(name, "held source", h_src, d_source_o);
        check(name, "held size", h_size, d_size_o);
      end
      held   = d_valid_o && !d_ready_i;
      h_op   = d_opcode_o;
      h_data = d_data_o;
      h_err  = d_error_o;
      h_src  = d_source_o;
      h_size = d_size_o;
      done   = d_valid_o && d_ready_i;
      if (!done && n == WAIT_LIMIT) begin
        abort("d_valid_o");
      end
      n++;
    end
    check(name, "opcode", op, d_opcode_o);
    check(name, "size", size, d_size_o);
    check(name, "source", src, d_source_o);
    check(name, "error", err, d_error_o);
    if (chk_data) begin
      check(name, "data", data, d_data_o);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic put_word(input string name, input tl_addr_t addr, input tl_data_t data,
                          input tl_mask_t mask, input tl_a_op_e op, input tl_source_t src);
    send_a(op, '0, 3'd2, src, addr, mask, data);
    model[widx(addr)] = merge_bytes(model[widx(addr)], data, mask);
    recv_d(name, AccessAck, 3'd2, src, '0, 1'b0, 1'b0);
  endtask

  task automatic get_word(input string name, input tl_addr_t addr, input tl_source_t src);
    send_a(Get, '0, 3'd2, src, addr, 4'hf, '0);
    recv_d(name, AccessAckData, 3'd2, src, model[widx(addr)], 1'b1, 1'b0);
  endtask

  task automatic amo_word(input string name, input tl_param_t param, input tl_addr_t addr,
                          input tl_data_t opnd);
    tl_data_t old;
    old = model[widx(addr)];
    send_a(ArithmeticData, param, 3'd2, 4'h7, addr, 4'hf, opnd);
    model[widx(addr)] = amo_ref(param, old, opnd);
    recv_d(name, AccessAckData, 3'd2, 4'h7, old, 1'b1, 1'b0);
  endtask

  task automatic write_then_read();
    put_word("single put", 14'h010, 32'hcafe_f00d, 4'hf, PutFullData, 4'h3);
    get_word("single get", 14'h010, 4'h5);
  endtask

  task automatic partial_write();
    put_word("partial base", 14'h020, 32'h1122_3344, 4'hf, PutFullData, 4'h2);
    put_word("partial put", 14'h020, 32'haabb_ccdd, 4'b0101, PutPartialData, 4'h2);
    get_word("partial get", 14'h020, 4'h2);
  endtask

  task automatic burst_transfers();
    send_a(PutFullData, '0, 3'd3, 4'h9, 14'h040, 4'hf, 32'h0101_0101);
    send_a(PutFullData, '0, 3'd3, 4'h9, 14'h040, 4'hf, 32'h0202_0202);
    model[16] = 32'h0101_0101;
    model[17] = 32'h0202_0202;
    recv_d("burst put", AccessAck, 3'd3, 4'h9, '0, 1'b0, 1'b0);
    send_a(Get, '0, 3'd3, 4'ha, 14'h040, 4'hf, '0);
    recv_d("burst get beat 0", AccessAckData, 3'd3, 4'ha, model[16], 1'b1, 1'b0);
    recv_d("burst get beat 1", AccessAckData, 3'd3, 4'ha, model[17], 1'b1, 1'b0);
  endtask

  task automatic atomic_ops();
    // two cases per op where the first picks the operand and the second the stored word
    tl_param_t ops [9]   = '{MIN, MIN, MAX, MAX, MINU, MINU, MAXU, MAXU, ADD};
    tl_data_t  store [9] = '{32'd5, 32'hffff_fff9, 32'd5, 32'h7fff_0000, 32'hffff_0000,
                             32'd3, 32'd3, 32'hffff_fff0, 32'hffff_fffe};
    tl_data_t  opnd [9]  = '{32'hffff_fffd, 32'd2, 32'd100, 32'hffff_ffff, 32'h10,
                             32'h8000_0000, 32'h8000_0000, 32'd1, 32'd5};
    tl_data_t  old0;
    tl_data_t  old1;
    for (int i = 0; i < 9; i++) begin
      put_word("amo base", tl_addr_t'(14'h100 + 4 * i), store[i], 4'hf, PutFullData, 4'h1);
      amo_word("amo old", ops[i], tl_addr_t'(14'h100 + 4 * i), opnd[i]);
      get_word("amo new", tl_addr_t'(14'h100 + 4 * i), 4'h1);
    end
    put_word("amo burst base 0", 14'h180, 32'h0000_0010, 4'hf, PutFullData, 4'h1);
    put_word("amo burst base 1", 14'h184, 32'hffff_ffff, 4'hf, PutFullData, 4'h1);
    old0 = model[96];
    old1 = model[97];
    send_a(ArithmeticData, ADD, 3'd3, 4'h4, 14'h180, 4'hf, 32'd5);
    model[96] = amo_ref(ADD, old0, 32'd5);
    recv_d("amo burst beat 0", AccessAckData, 3'd3, 4'h4, old0, 1'b1, 1'b0);
    send_a(ArithmeticData, ADD, 3'd3, 4'h4, 14'h180, 4'hf, 32'd7);
    model[97] = amo_ref(ADD, old1, 32'd7);
    recv_d("amo burst beat 1", AccessAckData, 3'd3, 4'h4, old1, 1'b1, 1'b0);
    get_word("amo burst new 0", 14'h180, 4'h1);
    get_word("amo burst new 1", 14'h184, 4'h1);
  endtask

  task automatic intent_and_bad_param();
    int writes_before;
    put_word("intent base", 14'h200, 32'h5a5a_a5a5, 4'hf, PutFullData, 4'h1);
    writes_before = sram_writes;
    send_a(Intent, '0, 3'd2, 4'hb, 14'h200, 4'hf, 32'hffff_ffff);
    recv_d("intent", HintAck, 3'd2, 4'hb, '0, 1'b0, 1'b0);
    check("intent", "sram writes", writes_before, sram_writes);
    get_word("intent readback", 14'h200, 4'h1);
    // an ignored write would store the old word again
    writes_before = sram_writes;
    send_a(ArithmeticData, tl_param_t'(5), 3'd2, 4'hc, 14'h200, 4'hf, 32'd1);
    recv_d("bad param", AccessAckData, 3'd2, 4'hc, '0, 1'b0, 1'b1);
    check("bad param", "sram writes", writes_before, sram_writes);
    get_word("bad param readback", 14'h200, 4'h1);
  endtask

  task automatic random_back_pressure();
    tl_addr_t    addr;
    logic [31:0] r;
    bp_en = 1'b1;
    repeat (8) begin
      r    = $random(seed);
      addr = tl_addr_t'({r[7:0], 2'b00});
      r    = $random(seed);
      put_word("bp put", addr, r, 4'hf, PutFullData, 4'h6);
      get_word("bp get", addr, 4'h6);
      r = $random(seed);
      amo_word("bp amo", ADD, addr, r);
      get_word("bp get after amo", addr, 4'h6);
    end
    bp_en = 1'b0;
  endtask

  initial begin
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = Get;
    a_param_i   = '0;
    a_size_i    = 3'd2;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check("reset", "a_ready", 1'b1, a_ready_o);
    check("reset", "d_valid", 1'b0, d_valid_o);
    check("reset", "req", 1'b0, u_tluh_sram_top.u_sram_if.req);
    check("reset", "we", 1'b0, u_tluh_sram_top.u_sram_if.we);
    @(posedge clk_i);
    #1;
    write_then_read();
    partial_write();
    burst_transfers();
    atomic_ops();
    intent_and_bad_param();
    random_back_pressure();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- design/tluh_sram_top.sv
module tluh_sram_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 a_valid_i,
  input  tluh_pkg::tl_a_op_e   a_opcode_i,
  input  tluh_pkg::tl_param_t  a_param_i,
  input  tluh_pkg::tl_size_t   a_size_i,
  input  tluh_pkg::tl_source_t a_source_i,
  input  tluh_pkg::tl_addr_t   a_address_i,
  input  tluh_pkg::tl_mask_t   a_mask_i,
  input  tluh_pkg::tl_data_t   a_data_i,
  output logic                 a_ready_o,
  output logic                 d_valid_o,
  output tluh_pkg::tl_d_op_e   d_opcode_o,
  output tluh_pkg::tl_size_t   d_size_o,
  output tluh_pkg::tl_source_t d_source_o,
  output tluh_pkg::tl_data_t   d_data_o,
  output logic                 d_error_o,
  input  logic                 d_ready_i
);
  import tluh_pkg::*;

  // atomic operands and result
  tl_arith_e alu_op;
  tl_data_t  alu_old;
  tl_data_t  alu_operand;
  tl_data_t  alu_result;

  sram_if u_sram_if ();

  tluh_sram_adapter u_adapter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .a_valid_i     (a_valid_i),
    .a_opcode_i    (a_opcode_i),
    .a_param_i     (a_param_i),
    .a_size_i      (a_size_i),
    .a_source_i    (a_source_i),
    .a_address_i   (a_address_i),
    .a_mask_i      (a_mask_i),
    .a_data_i      (a_data_i),
    .a_ready_o     (a_ready_o),
    .d_valid_o     (d_valid_o),
    .d_opcode_o    (d_opcode_o),
    .d_size_o      (d_size_o),
    .d_source_o    (d_source_o),
    .d_data_o      (d_data_o),
    .d_error_o     (d_error_o),
    .d_ready_i     (d_ready_i),
    .sram          (u_sram_if.master),
    .alu_op_o      (alu_op),
    .alu_old_o     (alu_old),
    .alu_operand_o (alu_operand),
    .alu_result_i  (alu_result)
  );

  tluh_amo_alu u_alu (
    .op_i      (alu_op),
    .old_i     (alu_old),
    .operand_i (alu_operand),
    .result_o  (alu_result)
  );

  sram_mem u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sram   (u_sram_if.slave)
  );

endmodule

//--- design/tluh_sram_adapter.sv
module tluh_sram_adapter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 a_valid_i,
  input  tluh_pkg::tl_a_op_e   a_opcode_i,
  input  tluh_pkg::tl_param_t  a_param_i,
  input  tluh_pkg::tl_size_t   a_size_i,
  input  tluh_pkg::tl_source_t a_source_i,
  input  tluh_pkg::tl_addr_t   a_address_i,
  input  tluh_pkg::tl_mask_t   a_mask_i,
  input  tluh_pkg::tl_data_t   a_data_i,
  output logic                 a_ready_o,
  output logic                 d_valid_o,
  output tluh_pkg::tl_d_op_e   d_opcode_o,
  output tluh_pkg::tl_size_t   d_size_o,
  output tluh_pkg::tl_source_t d_source_o,
  output tluh_pkg::tl_data_t   d_data_o,
  output logic                 d_error_o,
  input  logic                 d_ready_i,
  sram_if.master               sram,
  output tluh_pkg::tl_arith_e  alu_op_o,
  output tluh_pkg::tl_data_t   alu_old_o,
  output tluh_pkg::tl_data_t   alu_operand_o,
  input  tluh_pkg::tl_data_t   alu_result_i
);
  import tluh_pkg::*;
  import sram_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    READ_WAIT,
    AMO_WRITE,
    RESP,
    WAIT_BEAT
  } state_e;

  state_e      state_q;
  state_e      state_d;

  // request held for the whole transaction
  tl_a_op_e    op_q;
  tl_param_t   param_q;
  tl_size_t    size_q;
  tl_source_t  source_q;
  logic        beat_q;
  sram_addr_t  addr_q;
  tl_mask_t    mask_q;
  tl_data_t    data_q;
  sram_data_t  old_q;
  sram_wmask_t wmask;

  // D beat register
  tl_d_op_e    d_opcode_q;
  tl_data_t    d_data_q;
  logic        d_error_q;
  logic        d_load;
  tl_d_op_e    d_opcode_d;
  tl_data_t    d_data_d;
  logic        d_error_d;

  logic        first_beat;
  logic        beat_step;
  logic        more_beats;
  logic        is_amo;
  logic        bad_param;
  logic        a_bad_param;

  assign a_ready_o   = (state_q == IDLE) || (state_q == WAIT_BEAT);
  assign first_beat  = (state_q == IDLE) && a_valid_i;
  assign more_beats  = (size_q == TL_SIZE_BURST) && !beat_q;
  assign is_amo      = (op_q == ArithmeticData);
  assign bad_param   = is_amo && (param_q > tl_param_t'(ADD));
  assign a_bad_param = a_param_i > tl_param_t'(ADD);

  // second word of a burst from the host or from a Get
  assign beat_step = ((state_q == WAIT_BEAT) && a_valid_i) ||
                     ((state_q == RESP) && (state_d == READ));

  always_comb begin
    state_d    = state_q;
    d_load     = 1'b0;
    d_opcode_d = AccessAck;
    d_data_d   = '0;
    d_error_d  = 1'b0;
    case (state_q)
      IDLE: begin
        if (a_valid_i) begin
          case (a_opcode_i)
            Get: begin
              state_d = READ;
            end
            PutFullData, PutPartialData: begin
              state_d = AMO_WRITE;
            end
            ArithmeticData: begin
              if (a_bad_param) begin
                state_d    = RESP;
                d_load     = 1'b1;
                d_opcode_d = AccessAckData;
                d_error_d  = 1'b1;
              end else begin
                state_d = READ;
              end
            end
            Intent: begin
              state_d    = RESP;
              d_load     = 1'b1;
              d_opcode_d = HintAck;
            end
            default: begin
              state_d   = RESP;
              d_load    = 1'b1;
              d_error_d = 1'b1;
            end
          endcase
        end
      end
      READ: begin
        if (sram.gnt) begin
          state_d = READ_WAIT;
        end
      end
      READ_WAIT: begin
        if (sram.rvalid) begin
          if (is_amo) begin
            state_d = AMO_WRITE;
          end else begin
            state_d    = RESP;
            d_load     = 1'b1;
            d_opcode_d = AccessAckData;
            d_data_d   = sram.rdata;
          end
        end
      end
      AMO_WRITE: begin
        if (sram.gnt) begin
          if (is_amo) begin
            state_d    = RESP;
            d_load     = 1'b1;
            d_opcode_d = AccessAckData;
            d_data_d   = old_q;
          end else if (more_beats) begin
            state_d = WAIT_BEAT;
          end else begin
            // one ack for the whole put
            state_d    = RESP;
            d_load     = 1'b1;
            d_opcode_d = AccessAck;
          end
        end
      end
      RESP: begin
        if (d_ready_i) begin
          if (more_beats && (op_q == Get)) begin
            state_d = READ;
          end else if (more_beats && is_amo) begin
            state_d = WAIT_BEAT;
          end else begin
            state_d = IDLE;
          end
        end
      end
      WAIT_BEAT: begin
        if (a_valid_i) begin
          if (bad_param) begin
            state_d    = RESP;
            d_load     = 1'b1;
            d_opcode_d = AccessAckData;
            d_error_d  = 1'b1;
          end else if (is_amo) begin
            state_d = READ;
          end else begin
            state_d = AMO_WRITE;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      op_q       <= Get;
      param_q    <= '0;
      size_q     <= '0;
      source_q   <= '0;
      beat_q     <= 1'b0;
      d_opcode_q <= AccessAck;
      d_error_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (first_beat) begin
        op_q     <= a_opcode_i;
        param_q  <= a_param_i;
        size_q   <= a_size_i;
        source_q <= a_source_i;
        beat_q   <= 1'b0;
      end else if (beat_step) begin
        beat_q <= 1'b1;
      end
      if (d_load) begin
        d_opcode_q <= d_opcode_d;
        d_error_q  <= d_error_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_beat) begin
      // byte address down to word index
      addr_q <= a_address_i[TL_WORD_LSB +: $bits(sram_addr_t)];
      mask_q <= a_mask_i;
      data_q <= a_data_i;
    end else if (beat_step) begin
      addr_q <= addr_q + sram_addr_t'(1);
      if (state_q == WAIT_BEAT) begin
        mask_q <= a_mask_i;
        data_q <= a_data_i;
      end
    end
    if ((state_q == READ_WAIT) && sram.rvalid) begin
      old_q <= sram.rdata;
    end
    if (d_load) begin
      d_data_q <= d_data_d;
    end
  end

  // byte lanes to bit lanes
  always_comb begin
    for (int b = 0; b < TL_DBW; b++) begin
      wmask[8*b +: 8] = {8{mask_q[b]}};
    end
  end

  // puts share the write state with atomics
  assign sram.req   = (state_q == READ) || (state_q == AMO_WRITE);
  assign sram.we    = (state_q == AMO_WRITE);
  assign sram.addr  = addr_q;
  assign sram.wdata = is_amo ? alu_result_i : data_q;
  assign sram.wmask = wmask;

  assign alu_op_o      = tl_arith_e'(param_q);
  assign alu_old_o     = old_q;
  assign alu_operand_o = data_q;

  assign d_valid_o  = (state_q == RESP);
  assign d_opcode_o = d_opcode_q;
  assign d_size_o   = size_q;
  assign d_source_o = source_q;
  assign d_data_o   = d_data_q;
  assign d_error_o  = d_error_q;

  // a stalled D beat keeps its contents
  d_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_opcode_o) && $stable(d_data_o)
                                && $stable(d_error_o) && $stable(d_source_o)
                                && $stable(d_size_o));

  // hints never reach the memory as writes
  intent_no_write_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sram.req && sram.we |-> (op_q != Intent));

  // SRAM traffic only while channel A is closed
  no_access_when_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sram.req |-> !a_ready_o);

endmodule

//--- design/sram_mem.sv
`include "tluh_settings.svh"

module sram_mem (
  input logic   clk_i,
  input logic   rst_ni,
  sram_if.slave sram
);
  import sram_pkg::*;

  sram_data_t mem_q [`SRAM_DEPTH];
  sram_data_t rdata_q;
  logic       rvalid_q;
  logic       access;

  // single port that is never busy
  assign sram.gnt = 1'b1;
  assign access   = sram.req && sram.gnt;

  // bit-masked write at the grant edge
  always_ff @(posedge clk_i) begin
    if (access && sram.we) begin
      mem_q[sram.addr] <= (mem_q[sram.addr] & ~sram.wmask) | (sram.wdata & sram.wmask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !sram.we) begin
      rdata_q <= mem_q[sram.addr];
    end
  end

  // rvalid pulses once per granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access && !sram.we;
    end
  end

  assign sram.rdata  = rdata_q;
  assign sram.rvalid = rvalid_q;

  // word index from the adapter must land inside the array
  addr_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sram.req |-> (int'(sram.addr) < `SRAM_DEPTH));

endmodule

//--- design/tluh_amo_alu.sv
module tluh_amo_alu (
  input  tluh_pkg::tl_arith_e op_i,
  input  tluh_pkg::tl_data_t  old_i,
  input  tluh_pkg::tl_data_t  operand_i,
  output tluh_pkg::tl_data_t  result_o
);
  import tluh_pkg::*;

  logic     old_lt_signed;
  logic     old_lt_unsigned;
  tl_data_t sum;

  // stored word compared against host operand
  assign old_lt_signed   = $signed(old_i) < $signed(operand_i);
  assign old_lt_unsigned = old_i < operand_i;

  // wraps on overflow
  assign sum = old_i + operand_i;

  always_comb begin
    case (op_i)
      MIN: begin
        result_o = old_lt_signed ? old_i : operand_i;
      end
      MAX: begin
        result_o = old_lt_signed ? operand_i : old_i;
      end
      MINU: begin
        result_o = old_lt_unsigned ? old_i : operand_i;
      end
      MAXU: begin
        result_o = old_lt_unsigned ? operand_i : old_i;
      end
      ADD: begin
        result_o = sum;
      end
      default: begin
        // undefined params leave the word as it was
        result_o = old_i;
      end
    endcase
  end

endmodule

//--- design/sram_if.sv
interface sram_if;
  import sram_pkg::*;

  logic        req;
  logic        gnt;
  logic        we;
  sram_addr_t  addr;
  sram_data_t  wdata;
  sram_wmask_t wmask;

  // read return one cycle after the grant
  sram_data_t  rdata;
  logic        rvalid;

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    output wmask,
    input  gnt,
    input  rdata,
    input  rvalid
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  wmask,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface

//--- design/sram_pkg.sv
`include "tluh_settings.svh"

package sram_pkg;

  // one stored word is one bus beat
  localparam int SRAM_DW = `TLUH_DW;

  // word index into the array
  typedef logic [`SRAM_AW-1:0] sram_addr_t;

  typedef logic [SRAM_DW-1:0] sram_data_t;

  // one bit per data bit
  typedef logic [SRAM_DW-1:0] sram_wmask_t;

endpackage

//--- design/tluh_pkg.sv
`include "tluh_settings.svh"

package tluh_pkg;

  // channel field widths
  localparam int TL_DW  = `TLUH_DW;
  localparam int TL_AW  = `TLUH_AW;
  localparam int TL_DBW = TL_DW / 8;
  localparam int TL_SZW = 3;
  localparam int TL_AIW = 4;
  localparam int TL_PW  = 3;
  localparam int TL_OPW = 3;

  // byte offset bits below the word index
  localparam int TL_WORD_LSB = $clog2(TL_DBW);

  typedef logic [TL_DW-1:0]  tl_data_t;
  typedef logic [TL_AW-1:0]  tl_addr_t;
  typedef logic [TL_DBW-1:0] tl_mask_t;
  typedef logic [TL_SZW-1:0] tl_size_t;
  typedef logic [TL_AIW-1:0] tl_source_t;
  typedef logic [TL_PW-1:0]  tl_param_t;

  // two beats of one word each
  localparam tl_size_t TL_SIZE_BURST = 3'd3;

  // channel A opcodes without LogicalData (3)
  typedef enum logic [TL_OPW-1:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    Get            = 3'h4,
    Intent         = 3'h5
  } tl_a_op_e;

  typedef enum logic [TL_OPW-1:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1,
    HintAck       = 3'h2
  } tl_d_op_e;

  // a_param of ArithmeticData
  typedef enum logic [TL_PW-1:0] {
    MIN  = 3'h0,
    MAX  = 3'h1,
    MINU = 3'h2,
    MAXU = 3'h3,
    ADD  = 3'h4
  } tl_arith_e;

endpackage

//--- design/tluh_settings.svh
`ifndef TLUH_SETTINGS_SVH
`define TLUH_SETTINGS_SVH

// bus data width in bits
`define TLUH_DW 32

// byte address width on channel A
`define TLUH_AW 14

// word index width of the SRAM
`define SRAM_AW 8

// number of stored words
`define SRAM_DEPTH 256

`endif
